// ==== sim.f ====
logic/dcache_pkg.sv
logic/dcache_ifs.sv
logic/dcache_tag_array.sv
logic/dcache_data_array.sv
logic/dcache_ctrl.sv
logic/dcache_load_align.sv
logic/dcache_top.sv
sim/mem_model.sv
sim/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := dcache_tb
FILELIST  := sim.f
FLAGS     := --binary --timing --Wno-fatal -j 0
OBJDIR    := obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== sim/dcache_tb.sv ====
module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int n_req = 241;
    localparam int cycle_limit = 20 * n_req * 12;

    logic clk;
    logic rst;
    logic req_valid;
    logic req_ready;
    logic [core_addr_w-1:0] req_addr;
    logic [arch_w-1:0] req_wdata;
    dtype_t req_dtype;
    rtype_t req_rtype;
    logic rsp_valid;
    logic [arch_w-1:0] rsp_data;
    logic mem_r_valid;
    logic [mem_addr_w-1:0] mem_r_addr;
    logic mem_rsp_valid;
    logic mem_rsp_ready;
    logic [mem_data_w-1:0] mem_rsp_data;
    logic mem_w_valid;
    logic [mem_addr_w-1:0] mem_w_addr;
    logic [mem_data_w-1:0] mem_w_data;

    logic [7:0] ref_bytes [1 << core_addr_w];
    logic [mem_addr_w-1:0] rd_log [$];
    logic [mem_addr_w-1:0] wr_addr_log [$];
    logic [mem_data_w-1:0] wr_data_log [$];
    int cycle_cnt;
    int last_wait;
    logic rst_q;

    dcache_top UUT (.*);

    mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .r_valid   (mem_r_valid),
        .r_addr    (mem_r_addr),
        .rsp_ready (mem_rsp_ready),
        .rsp_valid (mem_rsp_valid),
        .rsp_data  (mem_rsp_data),
        .w_valid   (mem_w_valid),
        .w_addr    (mem_w_addr),
        .w_data    (mem_w_data)
    );

    always #10 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("Mismatch %s expected %0h actual %0h", name, exp, act);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // memory traffic and reset behavior sampled before the edge updates
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            report_error("timeout, the cache stopped answering");
        end
        if (rst_q) begin
            assert (!req_ready && !rsp_valid && !mem_r_valid && !mem_w_valid)
            else report_error("outputs active during or right after reset");
        end
        if (!rst) begin
            assert (mem_rsp_ready == mem_r_valid)
            else report_error("mem_rsp_ready does not follow the read request");
        end
        rst_q <= rst;
        if (mem_r_valid) begin
            rd_log.push_back(mem_r_addr);
        end
        if (mem_w_valid) begin
            wr_addr_log.push_back(mem_w_addr);
            wr_data_log.push_back(mem_w_data);
        end
    end

    function automatic logic [127:0] ref_beat(input logic [mem_addr_w-1:0] beat);
        logic [127:0] d;
        for (int b = 0; b < mem_data_bytes; b++) begin
            d[b*8 +: 8] = ref_bytes[{beat, 4'(b)}];
        end
        return d;
    endfunction

    // expected load value from the written bytes and the extension rule
    function automatic logic [31:0] expect_load(input logic [15:0] addr, input dtype_t dt);
        logic [15:0] h;
        logic [7:0] b;
        logic uns;
        uns = dt[2];
        b = ref_bytes[addr];
        h = {ref_bytes[addr + 16'd1], ref_bytes[addr]};
        case (dt[1:0])
            size_byte: return {{24{!uns && b[7]}}, b};
            size_half: return addr[0] ? 32'd0 : {{16{!uns && h[15]}}, h};
            default: begin
                if (addr[1:0] != 2'b00) begin
                    return 32'd0;
                end
                return {ref_bytes[addr + 16'd3], ref_bytes[addr + 16'd2], h};
            end
        endcase
    endfunction

    task automatic apply_store(input logic [15:0] addr, input dtype_t dt,
                               input logic [31:0] wd);
        int n;
        n = (dt[1:0] == size_byte) ? 1 : (dt[1:0] == size_half) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_bytes[addr + 16'(i)] = wd[i*8 +: 8];
        end
    endtask

    // drives one request from a falling edge until it completes
    task automatic run_request(input string name, input logic [15:0] addr, input rtype_t rt,
                               input dtype_t dt, input logic [31:0] wd);
        logic [31:0] exp;
        logic [mem_addr_w-1:0] base;
        rd_log.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        req_valid = 1'b1;
        req_addr = addr;
        req_rtype = rt;
        req_dtype = dt;
        req_wdata = wd;
        while (!req_ready) begin
            @(negedge clk);
        end
        exp = expect_load(addr, dt);
        @(negedge clk);
        req_valid = 1'b0;
        last_wait = 0;
        if (rt == rtype_read) begin
            while (!rsp_valid) begin
                @(negedge clk);
                last_wait++;
            end
            assert (rsp_data == exp) else report_mismatch(name, exp, rsp_data);
            assert (req_ready) else report_error("req_ready low with the load response");
        end else begin
            while (!req_ready) begin
                @(negedge clk);
                last_wait++;
            end
        end
        if (rd_log.size() != 0) begin
            assert (rd_log.size() == 4) else report_error("fill did not take 4 reads");
            for (int i = 0; i < 4; i++) begin
                base = {addr[15:6], 2'(i)};
                assert (rd_log[i] == base) else report_mismatch({name, " read addr"}, base,
                                                                rd_log[i]);
            end
        end
        if (wr_addr_log.size() != 0) begin
            assert (wr_addr_log.size() == 4) else report_error("write-back not 4 beats");
            for (int i = 0; i < 4; i++) begin
                base = {wr_addr_log[0][11:2], 2'(i)};
                assert (wr_addr_log[i] == base && base[4:2] == addr[8:6])
                else report_mismatch({name, " write addr"}, base, wr_addr_log[i]);
                assert (wr_data_log[i] == ref_beat(base))
                else report_mismatch({name, " write data"}, ref_beat(base), wr_data_log[i]);
            end
        end
        if (rt == rtype_write) begin
            apply_store(addr, dt, wd);
        end
    endtask

    task automatic expect_reads(input string name, input int n);
        assert (rd_log.size() == n) else report_mismatch(name, 128'(n), 128'(rd_log.size()));
    endtask

    initial begin
        logic [15:0] a;
        logic [1:0] sz;
        logic uns;
        rtype_t rt;
        void'($urandom(32'h0d58f7f3));
        for (int i = 0; i < (1 << core_addr_w); i++) begin
            a = 16'(i);
            ref_bytes[i] = a[7:0] ^ a[15:8] ^ 8'h96;
        end
        clk = 1'b0;
        rst = 1'b1;
        rst_q = 1'b0;
        cycle_cnt = 0;
        req_valid = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_dtype = dtype_word;
        req_rtype = rtype_read;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // miss then hit on one line
        run_request("load miss", 16'h0040, rtype_read, dtype_word, 0);
        expect_reads("load miss reads", 4);
        run_request("load hit", 16'h0044, rtype_read, dtype_word, 0);
        expect_reads("load hit reads", 0);
        assert (last_wait == 0) else report_mismatch("hit latency", 0, 128'(last_wait));

        // sizes, signs and misaligned accesses
        run_request("sw sign", 16'h0040, rtype_write, dtype_word, 32'h80ff7f01);
        run_request("sw sign2", 16'h0048, rtype_write, dtype_word, 32'h8001ff7f);
        for (int o = 0; o < 4; o++) begin
            run_request("lb", 16'h0040 + 16'(o), rtype_read, dtype_byte, 0);
            run_request("lbu", 16'h0040 + 16'(o), rtype_read, dtype_ubyte, 0);
            run_request("lb2", 16'h0048 + 16'(o), rtype_read, dtype_byte, 0);
        end
        for (int o = 0; o < 4; o += 2) begin
            run_request("lh", 16'h0040 + 16'(o), rtype_read, dtype_half, 0);
            run_request("lhu", 16'h0048 + 16'(o), rtype_read, dtype_uhalf, 0);
        end
        run_request("lh misaligned", 16'h0041, rtype_read, dtype_half, 0);
        run_request("lw misaligned", 16'h0042, rtype_read, dtype_word, 0);

        // stores on hit and on miss
        run_request("sb hit", 16'h0051, rtype_write, dtype_byte, 32'h000000a5);
        run_request("sh hit", 16'h0056, rtype_write, dtype_half, 32'h0000c3d2);
        run_request("lw after sb", 16'h0050, rtype_read, dtype_word, 0);
        run_request("lw after sh", 16'h0054, rtype_read, dtype_word, 0);
        run_request("sb miss", 16'h0085, rtype_write, dtype_byte, 32'h0000005e);
        expect_reads("store miss reads", 4);
        run_request("sh after miss", 16'h008a, rtype_write, dtype_half, 32'h0000b00c);
        run_request("lw store miss", 16'h0084, rtype_read, dtype_word, 0);
        run_request("lw store miss2", 16'h0088, rtype_read, dtype_word, 0);

        // write-back of dirty victims in set 3
        run_request("dirty x", 16'h00c4, rtype_write, dtype_word, 32'h11223344);
        run_request("dirty y", 16'h02c8, rtype_write, dtype_word, 32'h55667788);
        run_request("evict x", 16'h04c0, rtype_read, dtype_word, 0);
        assert (wr_addr_log.size() == 4 && wr_addr_log[0] == 12'h00c)
        else report_error("line x was not written back");
        run_request("reload x", 16'h00c4, rtype_read, dtype_word, 0);
        assert (wr_addr_log.size() == 4 && wr_addr_log[0] == 12'h02c)
        else report_error("line y was not written back");
        run_request("reload y", 16'h02c8, rtype_read, dtype_word, 0);

        // LRU order in set 4
        run_request("lru a", 16'h0100, rtype_read, dtype_word, 0);
        run_request("lru b", 16'h0300, rtype_read, dtype_word, 0);
        run_request("lru a again", 16'h0104, rtype_read, dtype_word, 0);
        run_request("lru c", 16'h0500, rtype_read, dtype_word, 0);
        run_request("lru reload a", 16'h0108, rtype_read, dtype_word, 0);
        expect_reads("reload a reads", 0);
        run_request("lru reload b", 16'h0300, rtype_read, dtype_word, 0);
        expect_reads("reload b reads", 4);

        // random traffic over four tags in two sets
        for (int i = 0; i < 200; i++) begin
            a = 16'((($urandom % 4) << 9) | (($urandom % 2) << 6) | ($urandom % 64));
            sz = 2'($urandom % 3);
            rt = rtype_t'($urandom % 2);
            if (rt == rtype_write) begin
                a = (sz == size_half) ? {a[15:1], 1'b0} :
                    (sz == size_word) ? {a[15:2], 2'b00} : a;
                run_request("random store", a, rt, dtype_t'({1'b0, sz}), $urandom);
            end else begin
                uns = (sz != size_word) && ($urandom % 2 == 1);
                run_request("random load", a, rt, dtype_t'({uns, sz}), 0);
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== sim/mem_model.sv ====
module mem_model (
    input  logic clk,
    input  logic rst,
    input  logic r_valid,
    input  logic [dcache_pkg::mem_addr_w-1:0] r_addr,
    input  logic rsp_ready,
    output logic rsp_valid,
    output logic [dcache_pkg::mem_data_w-1:0] rsp_data,
    input  logic w_valid,
    input  logic [dcache_pkg::mem_addr_w-1:0] w_addr,
    input  logic [dcache_pkg::mem_data_w-1:0] w_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    logic [mem_data_w-1:0] mem [1 << mem_addr_w];

    // every byte depends on both halves of its byte address
    initial begin
        logic [15:0] a;
        for (int i = 0; i < (1 << mem_addr_w); i++) begin
            for (int b = 0; b < mem_data_bytes; b++) begin
                a = 16'(i * mem_data_bytes + b);
                mem[i][b*8 +: 8] = a[7:0] ^ a[15:8] ^ 8'h96;
            end
        end
    end

    // read data one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= r_valid && rsp_ready;
        end
        rsp_data <= mem[r_addr];
    end

    // write-back beats land at their beat address
    always_ff @(posedge clk) begin
        if (w_valid) begin
            mem[w_addr] <= w_data;
        end
    end

endmodule

// ==== logic/dcache_top.sv ====
module dcache_top (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    output logic req_ready,
    input  logic [dcache_pkg::core_addr_w-1:0] req_addr,
    input  logic [dcache_pkg::arch_w-1:0] req_wdata,
    input  dcache_pkg::dtype_t req_dtype,
    input  dcache_pkg::rtype_t req_rtype,
    output logic rsp_valid,
    output logic [dcache_pkg::arch_w-1:0] rsp_data,
    output logic mem_r_valid,
    output logic [dcache_pkg::mem_addr_w-1:0] mem_r_addr,
    input  logic mem_rsp_valid,
    output logic mem_rsp_ready,
    input  logic [dcache_pkg::mem_data_w-1:0] mem_rsp_data,
    output logic mem_w_valid,
    output logic [dcache_pkg::mem_addr_w-1:0] mem_w_addr,
    output logic [dcache_pkg::mem_data_w-1:0] mem_w_data
);
    import dcache_pkg::*;

    logic req_fire;
    logic [arch_w-1:0] load_word;
    dtype_t load_dtype;
    logic [1:0] load_offset;

    dcache_lookup_if lk ();
    dcache_fill_if fa ();

    assign req_fire = req_valid && req_ready;

    dcache_tag_array u_tags (
        .clk      (clk),
        .rst      (rst),
        .req_addr (req_addr),
        .req_fire (req_fire),
        .lk       (lk.tags)
    );

    dcache_data_array u_data (
        .clk (clk),
        .fa  (fa.array)
    );

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_dtype     (req_dtype),
        .req_rtype     (req_rtype),
        .rsp_valid     (rsp_valid),
        .load_word     (load_word),
        .load_dtype    (load_dtype),
        .load_offset   (load_offset),
        .mem_r_valid   (mem_r_valid),
        .mem_r_addr    (mem_r_addr),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_data  (mem_rsp_data),
        .mem_w_valid   (mem_w_valid),
        .mem_w_addr    (mem_w_addr),
        .mem_w_data    (mem_w_data),
        .lk            (lk.ctrl),
        .fa            (fa.ctrl)
    );

    dcache_load_align u_align (
        .load_word   (load_word),
        .load_dtype  (load_dtype),
        .load_offset (load_offset),
        .rsp_data    (rsp_data)
    );

endmodule

// ==== logic/dcache_load_align.sv ====
module dcache_load_align (
    input  logic [dcache_pkg::arch_w-1:0] load_word,
    input  dcache_pkg::dtype_t load_dtype,
    input  logic [1:0] load_offset,
    output logic [dcache_pkg::arch_w-1:0] rsp_data
);
    import dcache_pkg::*;

    logic [1:0] size;
    logic uns;
    logic misaligned;
    logic [7:0] sel_byte;
    logic [15:0] sel_half;

    assign size = load_dtype[1:0];
    assign uns = load_dtype[2];

    // half needs an even offset, word needs offset zero
    assign misaligned = ((size == size_half) && load_offset[0]) ||
                        ((size == size_word) && (load_offset != 2'b00));

    assign sel_byte = load_word[{load_offset, 3'b000} +: 8];
    assign sel_half = load_offset[1] ? load_word[31:16] : load_word[15:0];

    always_comb begin
        rsp_data = '0;
        if (!misaligned) begin
            case (size)
                size_byte: rsp_data = {{24{!uns && sel_byte[7]}}, sel_byte};
                size_half: rsp_data = {{16{!uns && sel_half[15]}}, sel_half};
                size_word: rsp_data = load_word;
                default:   rsp_data = '0;
            endcase
        end
    end

endmodule

// ==== logic/dcache_ctrl.sv ====
module dcache_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    output logic req_ready,
    input  logic [dcache_pkg::core_addr_w-1:0] req_addr,
    input  logic [dcache_pkg::arch_w-1:0] req_wdata,
    input  dcache_pkg::dtype_t req_dtype,
    input  dcache_pkg::rtype_t req_rtype,
    output logic rsp_valid,
    output logic [dcache_pkg::arch_w-1:0] load_word,
    output dcache_pkg::dtype_t load_dtype,
    output logic [1:0] load_offset,
    output logic mem_r_valid,
    output logic [dcache_pkg::mem_addr_w-1:0] mem_r_addr,
    input  logic mem_rsp_valid,
    output logic mem_rsp_ready,
    input  logic [dcache_pkg::mem_data_w-1:0] mem_rsp_data,
    output logic mem_w_valid,
    output logic [dcache_pkg::mem_addr_w-1:0] mem_w_addr,
    output logic [dcache_pkg::mem_data_w-1:0] mem_w_data,
    dcache_lookup_if.ctrl lk,
    dcache_fill_if.ctrl fa
);
    import dcache_pkg::*;

    dcache_state_t state, state_nx;

    // accepted request, it also stays put as the pending one during a miss
    logic req_fire;
    logic req_q_valid;
    logic [core_addr_w-1:0] req_q_addr;
    logic [arch_w-1:0] req_q_wdata;
    dtype_t req_q_dtype;
    rtype_t req_q_rtype;
    logic hit_q;
    logic [way_w-1:0] way_q;
    logic victim_dirty_q;
    logic [tag_w-1:0] victim_tag_q;
    logic [idx_w-1:0] set_q;

    logic [beat_w-1:0] rd_cnt;
    logic [beat_w-1:0] wr_cnt;
    logic [beat_w-1:0] fill_cnt;
    logic last_fill;
    logic fill_done;

    logic miss_now;
    logic load_hit;
    logic store_hit;
    logic store_merge;
    logic store_now;
    logic [3:0] size_mask;
    logic [mem_data_bytes-1:0] store_mask;
    logic [mem_data_w-1:0] store_data;

    assign req_fire = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q_valid <= 1'b0;
            hit_q <= 1'b0;
            victim_dirty_q <= 1'b0;
        end else begin
            req_q_valid <= req_fire;
            if (req_fire) begin
                hit_q <= lk.hit;
                victim_dirty_q <= lk.victim_dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_q_addr <= req_addr;
            req_q_wdata <= req_wdata;
            req_q_dtype <= req_dtype;
            req_q_rtype <= req_rtype;
            // on a miss the victim way is where the new line goes
            way_q <= lk.hit ? lk.hit_way : lk.victim_way;
            victim_tag_q <= lk.victim_tag;
        end
    end

    assign set_q = req_q_addr[line_byte_w +: idx_w];

    assign miss_now = req_q_valid && !hit_q;
    assign load_hit = req_q_valid && hit_q && (req_q_rtype == rtype_read);
    assign store_hit = req_q_valid && hit_q && (req_q_rtype == rtype_write);
    // fill_done only shows up in the miss state for a store
    assign store_merge = (state == st_miss) && fill_done;
    assign store_now = store_hit || store_merge;

    assign last_fill = mem_rsp_valid && (fill_cnt == beat_w'(last_beat));

    // beat counters, all wrap back to zero after a full line
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cnt <= '0;
            wr_cnt <= '0;
            fill_cnt <= '0;
            fill_done <= 1'b0;
        end else begin
            if (mem_r_valid) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (mem_w_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (mem_rsp_valid) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            fill_done <= last_fill;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_reset;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            st_reset: state_nx = st_ready;
            st_ready: begin
                if (miss_now) begin
                    state_nx = victim_dirty_q ? st_evict : st_miss;
                end
            end
            st_evict: begin
                if (wr_cnt == beat_w'(last_beat)) begin
                    state_nx = st_miss;
                end
            end
            st_miss: begin
                // a load leaves on the last beat, a store after its merge
                if ((last_fill && (req_q_rtype == rtype_read)) || fill_done) begin
                    state_nx = st_ready;
                end
            end
            default: state_nx = st_reset;
        endcase
    end

    always_comb begin
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        mem_r_valid = 1'b0;
        mem_w_valid = 1'b0;
        case (state)
            st_ready: begin
                req_ready = !miss_now;
                rsp_valid = load_hit || fill_done;
                // first beat goes out right away
                mem_r_valid = miss_now && !victim_dirty_q;
                mem_w_valid = miss_now && victim_dirty_q;
            end
            st_evict: begin
                mem_w_valid = 1'b1;
                // refill starts alongside the last write-back beat
                mem_r_valid = (wr_cnt == beat_w'(last_beat));
            end
            st_miss: mem_r_valid = (rd_cnt != '0);
            default: ;
        endcase
    end

    assign mem_rsp_ready = mem_r_valid;
    assign mem_r_addr = {req_q_addr[core_addr_w-1:line_byte_w], rd_cnt};
    assign mem_w_addr = {victim_tag_q, set_q, wr_cnt};
    assign mem_w_data = fa.rd_line.q[wr_cnt];

    always_comb begin
        case (req_q_dtype[1:0])
            size_byte: size_mask = 4'b0001;
            size_half: size_mask = 4'b0011;
            default:   size_mask = 4'b1111;
        endcase
    end

    // store bytes placed at their offset inside the beat
    assign store_mask = mem_data_bytes'(size_mask) << req_q_addr[3:0];
    assign store_data = mem_data_w'(req_q_wdata) << {req_q_addr[3:0], 3'b000};

    always_comb begin
        fa.wr_en = mem_rsp_valid || store_now;
        fa.wr_way = way_q;
        fa.wr_set = set_q;
        if (mem_rsp_valid) begin
            fa.wr_beat = fill_cnt;
            fa.wr_mask = '1;
            fa.wr_data = mem_rsp_data;
        end else begin
            fa.wr_beat = req_q_addr[line_byte_w-1 -: beat_w];
            fa.wr_mask = store_mask;
            fa.wr_data = store_data;
        end
    end

    assign fa.rd_way = way_q;
    assign fa.rd_set = set_q;

    assign lk.upd_valid = last_fill;
    assign lk.upd_way = way_q;
    assign lk.upd_set = set_q;
    assign lk.upd_tag = req_q_addr[core_addr_w-1 -: tag_w];
    assign lk.mark_dirty = store_now;
    assign lk.lru_touch = load_hit || store_hit || last_fill;

    assign load_word = fa.rd_line.w[req_q_addr[line_byte_w-1:2]];
    assign load_dtype = req_q_dtype;
    assign load_offset = req_q_addr[1:0];

endmodule

// ==== logic/dcache_data_array.sv ====
module dcache_data_array (
    input  logic clk,
    dcache_fill_if.array fa
);
    import dcache_pkg::*;

    cache_line_u lines [ways][sets];

    // one beat per cycle, only the enabled bytes change
    always_ff @(posedge clk) begin
        if (fa.wr_en) begin
            for (int b = 0; b < mem_data_bytes; b++) begin
                if (fa.wr_mask[b]) begin
                    lines[fa.wr_way][fa.wr_set].q[fa.wr_beat][b*8 +: 8] <=
                        fa.wr_data[b*8 +: 8];
                end
            end
        end
    end

    // whole line out, the controller picks a word or a beat from it
    assign fa.rd_line = lines[fa.rd_way][fa.rd_set];

endmodule

// ==== logic/dcache_tag_array.sv ====
module dcache_tag_array (
    input  logic clk,
    input  logic rst,
    input  logic [dcache_pkg::core_addr_w-1:0] req_addr,
    input  logic req_fire,
    dcache_lookup_if.tags lk
);
    import dcache_pkg::*;

    logic valid_r [ways][sets];
    logic dirty_r [ways][sets];
    logic [tag_w-1:0] tag_r [ways][sets];
    logic [way_w-1:0] lru_r [ways][sets];

    logic [idx_w-1:0] req_set;
    logic [tag_w-1:0] req_tag;
    logic touch_same_set;
    logic [way_w-1:0] lru_eff [ways];

    assign req_set = req_addr[line_byte_w +: idx_w];
    assign req_tag = req_addr[core_addr_w-1 -: tag_w];

    // a hit from the previous request may touch this set in the same cycle
    assign touch_same_set = lk.lru_touch && (lk.upd_set == req_set);

    // counters as they will stand after that touch
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            lru_eff[w] = lru_r[w][req_set];
            if (touch_same_set) begin
                if (w == int'(lk.upd_way)) begin
                    lru_eff[w] = '0;
                end else if (lru_r[w][req_set] < lru_r[lk.upd_way][req_set]) begin
                    lru_eff[w] = lru_r[w][req_set] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        lk.hit = 1'b0;
        lk.hit_way = '0;
        lk.victim_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (valid_r[w][req_set] && (tag_r[w][req_set] == req_tag)) begin
                lk.hit = req_fire;
                lk.hit_way = way_w'(w);
            end
            // oldest way is the one at the top count
            if (lru_eff[w] == way_w'(ways - 1)) begin
                lk.victim_way = way_w'(w);
            end
        end
    end

    assign lk.victim_dirty = dirty_r[lk.victim_way][req_set];
    assign lk.victim_tag = tag_r[lk.victim_way][req_set];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < ways; w++) begin
                for (int s = 0; s < sets; s++) begin
                    valid_r[w][s] <= 1'b0;
                    dirty_r[w][s] <= 1'b0;
                end
            end
        end else begin
            // a fresh line arrives clean, a merged store dirties it afterwards
            if (lk.upd_valid) begin
                valid_r[lk.upd_way][lk.upd_set] <= 1'b1;
                dirty_r[lk.upd_way][lk.upd_set] <= 1'b0;
            end
            if (lk.mark_dirty) begin
                dirty_r[lk.upd_way][lk.upd_set] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lk.upd_valid) begin
            tag_r[lk.upd_way][lk.upd_set] <= lk.upd_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < ways; w++) begin
                for (int s = 0; s < sets; s++) begin
                    lru_r[w][s] <= way_w'(w);
                end
            end
        end else if (lk.lru_touch) begin
            for (int w = 0; w < ways; w++) begin
                if (lru_r[w][lk.upd_set] < lru_r[lk.upd_way][lk.upd_set]) begin
                    lru_r[w][lk.upd_set] <= lru_r[w][lk.upd_set] + 1'b1;
                end
            end
            lru_r[lk.upd_way][lk.upd_set] <= '0;
        end
    end

endmodule

// ==== logic/dcache_ifs.sv ====
interface dcache_lookup_if;
    import dcache_pkg::*;

    // lookup result for the request being accepted
    logic hit;
    logic [way_w-1:0] hit_way;
    logic [way_w-1:0] victim_way;
    logic victim_dirty;
    logic [tag_w-1:0] victim_tag;

    // state updates, all aimed at upd_way/upd_set
    logic upd_valid;
    logic [way_w-1:0] upd_way;
    logic [idx_w-1:0] upd_set;
    logic [tag_w-1:0] upd_tag;
    logic mark_dirty;
    logic lru_touch;

    modport tags (
        output hit, hit_way, victim_way, victim_dirty, victim_tag,
        input  upd_valid, upd_way, upd_set, upd_tag, mark_dirty, lru_touch
    );

    modport ctrl (
        input  hit, hit_way, victim_way, victim_dirty, victim_tag,
        output upd_valid, upd_way, upd_set, upd_tag, mark_dirty, lru_touch
    );

endinterface

interface dcache_fill_if;
    import dcache_pkg::*;

    logic wr_en;
    logic [way_w-1:0] wr_way;
    logic [idx_w-1:0] wr_set;
    logic [beat_w-1:0] wr_beat;
    logic [mem_data_bytes-1:0] wr_mask;
    logic [mem_data_w-1:0] wr_data;
    logic [way_w-1:0] rd_way;
    logic [idx_w-1:0] rd_set;
    cache_line_u rd_line;

    modport array (
        input  wr_en, wr_way, wr_set, wr_beat, wr_mask, wr_data, rd_way, rd_set,
        output rd_line
    );

    modport ctrl (
        output wr_en, wr_way, wr_set, wr_beat, wr_mask, wr_data, rd_way, rd_set,
        input  rd_line
    );

endinterface

// ==== logic/dcache_pkg.sv ====
package dcache_pkg;

    // core side
    localparam int core_addr_w = 16;
    localparam int arch_w = 32;

    // memory side, one address unit is one 16-byte beat
    localparam int mem_addr_w = 12;
    localparam int mem_data_w = 128;
    localparam int mem_data_bytes = 16;

    // geometry
    localparam int sets = 8;
    localparam int ways = 2;
    localparam int idx_w = 3;
    localparam int way_w = 1;
    localparam int line_byte_w = 6;
    localparam int tag_w = core_addr_w - idx_w - line_byte_w;
    localparam int line_words = 16;
    localparam int beats_per_line = 4;
    localparam int beat_w = 2;
    localparam int last_beat = beats_per_line - 1;

    // access size, the low two bits of the type code
    localparam logic [1:0] size_byte = 2'b00;
    localparam logic [1:0] size_half = 2'b01;
    localparam logic [1:0] size_word = 2'b10;

    // top bit selects zero extension on loads
    typedef enum logic [2:0] {
        dtype_byte  = {1'b0, size_byte},
        dtype_half  = {1'b0, size_half},
        dtype_word  = {1'b0, size_word},
        dtype_ubyte = {1'b1, size_byte},
        dtype_uhalf = {1'b1, size_half}
    } dtype_t;

    typedef enum logic {
        rtype_read  = 1'b0,
        rtype_write = 1'b1
    } rtype_t;

    typedef enum logic [1:0] {
        st_reset,
        st_ready,
        st_miss,
        st_evict
    } dcache_state_t;

    // beats for fill and write-back, words for loads
    typedef union packed {
        logic [beats_per_line-1:0][mem_data_w-1:0] q;
        logic [line_words-1:0][arch_w-1:0] w;
    } cache_line_u;

endpackage
